/* src.f */
imc_pkg.sv
prom_buffer.sv
row_array.sv
op_sequencer.sv
imc_core.sv
imc_core_asserts.sv
tb_imc_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_imc_core
FILELIST  = src.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

/* tb_imc_core.sv */
//////////////////////////////////////////////////
// random-stimulus testbench for imc_core
// row reference model, host and control bus tasks
// watchdog and closing error summary
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_imc_core
    import imc_pkg::*;
;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int PROG_LEN      = 40;
    localparam int RAND_LOADS    = 32;
    localparam int READ_LATENCY  = 3;
    localparam int READ_WAIT_MAX = 8;
    // fill, random loads, readbacks, pushes, run, two full sweeps
    localparam int PLANNED_CYCLES = RESET_CYCLES + 2*ROW_COUNT + 8*RAND_LOADS
                                  + 6*PROG_LEN + 2*6*ROW_COUNT + 64;
    localparam int WATCHDOG_NS   = 4 * PLANNED_CYCLES * CLK_PERIOD;

    logic        sys_clk_in;
    logic        sys_reset_in;
    host_req_t   host_req;
    host_rsp_t   host_rsp;
    csr_req_t    csr_req;
    csr_rsp_t    csr_rsp;
    logic        prom_irq;

    logic [WORD_W-1:0] model_rows [ROW_COUNT];
    logic [31:0]       rng_state = 32'h1ec2_87cd;
    int                value_errors = 0;
    int                protocol_errors = 0;

    imc_core imc_core_i (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .csr_req      (csr_req),
        .csr_rsp      (csr_rsp),
        .prom_irq     (prom_irq)
    );

    initial begin
        sys_clk_in = 1'b0;
        forever #(CLK_PERIOD/2) sys_clk_in = ~sys_clk_in;
    end

    // hard stop well past the planned test length
    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired, simulation did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        value_errors++;
        $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic report_problem(input string msg);
        protocol_errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // hold the request until an edge sees waitrequest low
    task automatic wait_accept();
        while (host_rsp.waitrequest) begin
            @(posedge sys_clk_in);
            #DRIVE_DLY;
        end
        @(posedge sys_clk_in);
        #DRIVE_DLY;
    endtask

    task automatic host_load(input logic [ROW_ADDR_W-1:0] row, input logic [31:0] data);
        @(posedge sys_clk_in);
        #DRIVE_DLY;
        host_req.write     = 1'b1;
        host_req.read      = 1'b0;
        host_req.address   = {1'b1, row};
        host_req.writedata = data;
        wait_accept();
        host_req.write = 1'b0;
        model_rows[row] = data;
    endtask

    // valid counted in falling edges after the accepting edge
    task automatic host_read_check(input logic [ROW_ADDR_W-1:0] row);
        int n;
        @(posedge sys_clk_in);
        #DRIVE_DLY;
        host_req.read    = 1'b1;
        host_req.write   = 1'b0;
        host_req.address = {1'b0, row};
        wait_accept();
        host_req.read = 1'b0;
        n = 1;
        @(negedge sys_clk_in);
        while (!host_rsp.readdatavalid && n < READ_WAIT_MAX) begin
            @(negedge sys_clk_in);
            n++;
        end
        if (!host_rsp.readdatavalid) begin
            report_problem($sformatf("no host readdatavalid for row %0d", row));
        end else begin
            if (n != READ_LATENCY) report_mismatch("host readdatavalid latency",
                                                   READ_LATENCY, n);
            if (host_rsp.readdata !== model_rows[row]) begin
                report_mismatch($sformatf("host readdata row %0d", row),
                                model_rows[row], host_rsp.readdata);
            end
            @(negedge sys_clk_in);
            if (host_rsp.readdatavalid) report_problem("host readdatavalid longer than a cycle");
        end
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge sys_clk_in);
        #DRIVE_DLY;
        csr_req.write     = 1'b1;
        csr_req.address   = addr;
        csr_req.writedata = data;
        @(posedge sys_clk_in);
        #DRIVE_DLY;
        csr_req.write = 1'b0;
    endtask

    task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge sys_clk_in);
        #DRIVE_DLY;
        csr_req.read    = 1'b1;
        csr_req.address = addr;
        @(posedge sys_clk_in);
        #DRIVE_DLY;
        csr_req.read = 1'b0;
        @(negedge sys_clk_in);
        if (!csr_rsp.readdatavalid) report_problem("no control readdatavalid after read");
        data = csr_rsp.readdata;
    endtask

    // reference compute rules with operands read before the write
    task automatic model_exec(input instr_t ins);
        logic [31:0] a;
        logic [31:0] b;
        a = model_rows[ins.src_a];
        b = model_rows[ins.src_b];
        case (ins.opcode)
            OP_MOVE:  model_rows[ins.src_b] = a;
            OP_ORC:   model_rows[ins.dst] = a | b;
            OP_ANDC:  model_rows[ins.dst] = a & b;
            OP_XORC:  model_rows[ins.dst] = a ^ b;
            OP_LSHFT: model_rows[ins.src_b] = a << ins.dst[SHIFT_W-1:0];
            OP_RSHFT: model_rows[ins.src_b] = a >> ins.dst[SHIFT_W-1:0];
            default: ;
        endcase
    endtask

    task automatic wait_irq(input int max_cycles);
        int n;
        n = 0;
        while (!prom_irq && n < max_cycles) begin
            @(negedge sys_clk_in);
            n++;
        end
        if (!prom_irq) report_problem("prom_irq did not rise after START");
    endtask

    initial begin
        logic [ROW_ADDR_W-1:0] addrs [RAND_LOADS];
        logic [31:0]           r;
        logic [31:0]           got;
        logic [7:0]            op_byte;
        logic [CSR_ADDR_W-1:0] bad_addr;
        sys_reset_in = 1'b1;
        host_req     = '0;
        csr_req      = '0;
        repeat (RESET_CYCLES) @(posedge sys_clk_in);
        #DRIVE_DLY;
        sys_reset_in = 1'b0;

        // quiet outputs once out of reset
        @(posedge sys_clk_in);
        @(negedge sys_clk_in);
        if (prom_irq !== 1'b0) report_mismatch("prom_irq", 0, prom_irq);
        if (host_rsp.readdatavalid !== 1'b0) begin
            report_mismatch("host readdatavalid", 0, host_rsp.readdatavalid);
        end
        if (csr_rsp.readdatavalid !== 1'b0) begin
            report_mismatch("csr readdatavalid", 0, csr_rsp.readdatavalid);
        end
        if (host_rsp.waitrequest !== 1'b0) begin
            report_mismatch("host waitrequest", 0, host_rsp.waitrequest);
        end

        // every row gets a known value first
        for (int i = 0; i < ROW_COUNT; i++) host_load(i[ROW_ADDR_W-1:0], rand_word());

        // random loads then readback
        for (int i = 0; i < RAND_LOADS; i++) begin
            r = rand_word();
            addrs[i] = r[ROW_ADDR_W-1:0];
            host_load(addrs[i], rand_word());
        end
        for (int i = 0; i < RAND_LOADS; i++) host_read_check(addrs[i]);

        // program with a share of unknown opcodes
        for (int i = 0; i < PROG_LEN; i++) begin
            r = rand_word();
            case (r[2:0])
                3'd0:    op_byte = OP_MOVE;
                3'd1:    op_byte = OP_ORC;
                3'd2:    op_byte = OP_ANDC;
                3'd3:    op_byte = OP_XORC;
                3'd4:    op_byte = OP_LSHFT;
                3'd5:    op_byte = OP_RSHFT;
                default: op_byte = {1'b1, r[10:4]};
            endcase
            r = rand_word();
            csr_write(CSR_PUSH, {op_byte, r[23:0]});
            model_exec(instr_t'({op_byte, r[23:0]}));
        end
        csr_write(CSR_START, '0);
        wait_irq(4*PROG_LEN + RESET_CYCLES);
        for (int i = 0; i < ROW_COUNT; i++) host_read_check(i[ROW_ADDR_W-1:0]);

        // control registers
        csr_read(CSR_STATUS, got);
        if (got !== 32'h2) report_mismatch("csr readdata STATUS", 32'h2, got);
        csr_read(CSR_WRPTR, got);
        if (got !== PROG_LEN) report_mismatch("csr readdata WRPTR", PROG_LEN, got);
        csr_write(CSR_CLEAR, '0);
        csr_read(CSR_WRPTR, got);
        if (got !== 32'h0) report_mismatch("csr readdata WRPTR", 32'h0, got);
        r = rand_word();
        bad_addr = 4'(6 + r % 10);
        csr_read(bad_addr, got);
        if (got !== BAD_READ_VALUE) report_mismatch("csr readdata unmapped", BAD_READ_VALUE, got);

        // irq clear then an empty run that leaves rows alone
        csr_write(CSR_IRQ_CLEAR, '0);
        if (prom_irq !== 1'b0) report_mismatch("prom_irq", 0, prom_irq);
        csr_write(CSR_START, '0);
        wait_irq(RESET_CYCLES);
        for (int i = 0; i < ROW_COUNT; i++) host_read_check(i[ROW_ADDR_W-1:0]);

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* imc_core_asserts.sv */
//////////////////////////////////////////////////
// concurrent checks on host, control and
// sequencer handshakes, bound into imc_core
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module imc_core_asserts
    import imc_pkg::*;
(
    input wire logic      sys_clk_in,
    input wire logic      sys_reset_in,
    input wire host_rsp_t host_rsp,
    input wire csr_req_t  csr_req,
    input wire csr_rsp_t  csr_rsp,
    input wire logic      instr_taken,
    input wire logic      instr_avail
);

    // host data never returned while stalled
    host_valid_not_stalled: assert property (@(posedge sys_clk_in) disable iff (sys_reset_in)
        !(host_rsp.readdatavalid && host_rsp.waitrequest))
        else $error("host readdatavalid high together with waitrequest");

    // control read answered on the next cycle
    csr_read_answered: assert property (@(posedge sys_clk_in) disable iff (sys_reset_in)
        csr_req.read |=> csr_rsp.readdatavalid)
        else $error("control read without readdatavalid one cycle later");

    // and valid only ever after a read
    csr_valid_after_read: assert property (@(posedge sys_clk_in) disable iff (sys_reset_in)
        csr_rsp.readdatavalid |-> $past(csr_req.read))
        else $error("control readdatavalid without a read the cycle before");

    // pointer only advances with work pending
    taken_needs_avail: assert property (@(posedge sys_clk_in) disable iff (sys_reset_in)
        instr_taken |-> instr_avail)
        else $error("instr_taken pulsed while instr_avail low");

endmodule

bind imc_core imc_core_asserts imc_core_asserts_i (
    .sys_clk_in   (sys_clk_in),
    .sys_reset_in (sys_reset_in),
    .host_rsp     (host_rsp),
    .csr_req      (csr_req),
    .csr_rsp      (csr_rsp),
    .instr_taken  (instr_taken),
    .instr_avail  (instr_avail)
);

`default_nettype wire

/* imc_core.sv */
//////////////////////////////////////////////////
// top level of the in-memory compute controller
// program buffer, row array and sequencer
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module imc_core
    import imc_pkg::*;
(
    input  wire logic      sys_clk_in,
    input  wire logic      sys_reset_in,
    input  wire host_req_t host_req,
    output host_rsp_t      host_rsp,
    input  wire csr_req_t  csr_req,
    output csr_rsp_t       csr_rsp,
    output logic           prom_irq
);

    // sequencer to array
    row_cmd_t          row_cmd;
    logic [WORD_W-1:0] rd_word_a;

    // buffer to sequencer
    instr_t            instr;
    logic              instr_avail;
    logic              run;

    // sequencer back to buffer
    logic              instr_taken;
    logic              seq_busy;

    prom_buffer prom_buffer_i (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .csr_req      (csr_req),
        .csr_rsp      (csr_rsp),
        .instr_taken  (instr_taken),
        .seq_busy     (seq_busy),
        .instr        (instr),
        .instr_avail  (instr_avail),
        .run          (run),
        .prom_irq     (prom_irq)
    );

    row_array row_array_i (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .row_cmd      (row_cmd),
        .rd_word_a    (rd_word_a)
    );

    op_sequencer op_sequencer_i (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .instr        (instr),
        .instr_avail  (instr_avail),
        .run          (run),
        .instr_taken  (instr_taken),
        .seq_busy     (seq_busy),
        .row_cmd      (row_cmd),
        .rd_word_a    (rd_word_a)
    );

endmodule

`default_nettype wire

/* op_sequencer.sv */
//////////////////////////////////////////////////
// sequencer FSM for host loads and reads
// and for buffered instruction execution
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module op_sequencer
    import imc_pkg::*;
(
    input  wire logic              sys_clk_in,
    input  wire logic              sys_reset_in,
    input  wire host_req_t         host_req,
    output host_rsp_t              host_rsp,
    input  wire instr_t            instr,
    input  wire logic              instr_avail,
    input  wire logic              run,
    output logic                   instr_taken,
    output logic                   seq_busy,
    output row_cmd_t               row_cmd,
    input  wire logic [WORD_W-1:0] rd_word_a
);

    seq_state_e state;
    seq_state_e next_state;

    // registered host response and array command
    host_rsp_t  rsp_q;
    host_rsp_t  next_rsp;
    row_cmd_t   cmd_q;
    row_cmd_t   next_cmd;

    // instruction held through its three phases
    instr_t     instr_q;

    logic       host_load;
    logic       host_read;

    // host requests only count while not stalled
    assign host_load = !rsp_q.waitrequest && host_req.write
                       && host_req.address[HOST_ADDR_W-1];
    assign host_read = !rsp_q.waitrequest && !host_req.write && host_req.read;

    always_ff @(posedge sys_clk_in or posedge sys_reset_in) begin
        if (sys_reset_in) begin
            state <= ST_IDLE;
            rsp_q <= '{waitrequest: 1'b1, readdata: '0, readdatavalid: 1'b0};
            cmd_q <= '0;
        end else begin
            state <= next_state;
            rsp_q <= next_rsp;
            cmd_q <= next_cmd;
        end
    end

    always_ff @(posedge sys_clk_in) begin
        if (instr_taken) begin
            instr_q <= instr;
        end
    end

    always_comb begin
        next_state                 = state;
        next_rsp                   = rsp_q;
        next_rsp.readdatavalid     = 1'b0;
        next_cmd                   = cmd_q;
        next_cmd.wr_en             = 1'b0;
        instr_taken                = 1'b0;

        case (state)
            ST_IDLE: begin
                // stall the host while a run is pending
                next_rsp.waitrequest = run;
                if (host_load) begin
                    next_cmd.wr_addr     = host_req.address[ROW_ADDR_W-1:0];
                    next_cmd.load_data   = host_req.writedata;
                    next_cmd.kind        = OP_LOAD;
                    next_rsp.waitrequest = 1'b1;
                    next_state           = ST_LOAD;
                end else if (host_read) begin
                    next_cmd.rd_addr_a   = host_req.address[ROW_ADDR_W-1:0];
                    next_rsp.waitrequest = 1'b1;
                    next_state           = ST_HREAD1;
                end else if (instr_avail) begin
                    instr_taken          = 1'b1;
                    next_rsp.waitrequest = 1'b1;
                    next_state           = ST_FETCH;
                end
            end

            // row written one edge after this state
            ST_LOAD: begin
                next_cmd.wr_en       = 1'b1;
                next_rsp.waitrequest = 1'b0;
                next_state           = ST_IDLE;
            end

            // array registers port a here
            ST_HREAD1: begin
                next_state = ST_HREAD2;
            end

            ST_HREAD2: begin
                next_rsp.readdata      = rd_word_a;
                next_rsp.readdatavalid = 1'b1;
                next_rsp.waitrequest   = 1'b0;
                next_state             = ST_IDLE;
            end

            // operand rows presented during ISSUE
            ST_FETCH: begin
                next_cmd.rd_addr_a = instr_q.src_a;
                next_cmd.rd_addr_b = instr_q.src_b;
                next_state         = ST_ISSUE;
            end

            // write strobe lands in EXEC
            ST_ISSUE: begin
                next_cmd.kind  = instr_q.opcode;
                next_cmd.shift = instr_q.dst[SHIFT_W-1:0];
                case (instr_q.opcode)
                    OP_ORC, OP_ANDC, OP_XORC: begin
                        next_cmd.wr_en   = 1'b1;
                        next_cmd.wr_addr = instr_q.dst;
                    end
                    // single operand ops target src_b
                    OP_MOVE, OP_LSHFT, OP_RSHFT: begin
                        next_cmd.wr_en   = 1'b1;
                        next_cmd.wr_addr = instr_q.src_b;
                    end
                    // unknown opcode, consumed without a write
                    default: begin
                        next_cmd.wr_en = 1'b0;
                    end
                endcase
                next_state = ST_EXEC;
            end

            ST_EXEC: begin
                next_rsp.waitrequest = run;
                next_state           = ST_IDLE;
            end

            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    assign seq_busy = (state != ST_IDLE);
    assign host_rsp = rsp_q;
    assign row_cmd  = cmd_q;

endmodule

`default_nettype wire

/* row_array.sv */
//////////////////////////////////////////////////
// row memory with two registered read ports
// row compute unit and single write port
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module row_array
    import imc_pkg::*;
(
    input  wire logic     sys_clk_in,
    input  wire logic     sys_reset_in,
    input  wire row_cmd_t row_cmd,
    output logic [WORD_W-1:0] rd_word_a
);

    // row storage
    logic [WORD_W-1:0] rows [ROW_COUNT];

    // registered read words
    logic [WORD_W-1:0] rd_q_a;
    logic [WORD_W-1:0] rd_q_b;

    // value to be written this cycle
    logic [WORD_W-1:0] result;

    // both ports read every cycle
    always_ff @(posedge sys_clk_in or posedge sys_reset_in) begin
        if (sys_reset_in) begin
            rd_q_a <= '0;
            rd_q_b <= '0;
        end else begin
            rd_q_a <= rows[row_cmd.rd_addr_a];
            rd_q_b <= rows[row_cmd.rd_addr_b];
        end
    end

    // compute on the words read in the previous cycle
    always_comb begin
        case (row_cmd.kind)
            OP_LOAD:  result = row_cmd.load_data;
            OP_MOVE:  result = rd_q_a;
            OP_ORC:   result = rd_q_a | rd_q_b;
            OP_ANDC:  result = rd_q_a & rd_q_b;
            OP_XORC:  result = rd_q_a ^ rd_q_b;
            // logical shifts, zero fill
            OP_LSHFT: result = rd_q_a << row_cmd.shift;
            OP_RSHFT: result = rd_q_a >> row_cmd.shift;
            default:  result = rd_q_a;
        endcase
    end

    // single write port
    always_ff @(posedge sys_clk_in) begin
        if (row_cmd.wr_en) begin
            rows[row_cmd.wr_addr] <= result;
        end
    end

    // port a goes back for host reads
    assign rd_word_a = rd_q_a;

endmodule

`default_nettype wire

/* prom_buffer.sv */
//////////////////////////////////////////////////
// program buffer with read and write pointers
// control register port and done interrupt
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module prom_buffer
    import imc_pkg::*;
(
    input  wire logic     sys_clk_in,
    input  wire logic     sys_reset_in,
    input  wire csr_req_t csr_req,
    output csr_rsp_t      csr_rsp,
    input  wire logic     instr_taken,
    input  wire logic     seq_busy,
    output instr_t        instr,
    output logic          instr_avail,
    output logic          run,
    output logic          prom_irq
);

    // instruction store
    logic [WORD_W-1:0]      prom_mem [PROM_DEPTH];

    logic [PROM_ADDR_W-1:0] wr_ptr;
    logic [PROM_ADDR_W-1:0] rd_ptr;
    logic                   run_q;
    logic                   irq_q;
    csr_rsp_t               rsp_q;
    logic [WORD_W-1:0]      rd_value;

    // decoded control writes
    logic push_wr;
    logic start_wr;
    logic clear_wr;
    logic irq_clear_wr;
    logic run_done;

    assign push_wr      = csr_req.write && (csr_req.address == CSR_PUSH);
    assign start_wr     = csr_req.write && (csr_req.address == CSR_START);
    assign clear_wr     = csr_req.write && (csr_req.address == CSR_CLEAR);
    assign irq_clear_wr = csr_req.write && (csr_req.address == CSR_IRQ_CLEAR);

    // work pending while pointers differ
    assign instr_avail = run_q && (rd_ptr != wr_ptr);

    // buffer drained and last instruction retired
    assign run_done = run_q && !instr_avail && !seq_busy;

    // pushes land at the write pointer
    always_ff @(posedge sys_clk_in) begin
        if (push_wr) begin
            prom_mem[wr_ptr] <= csr_req.writedata;
        end
    end

    // current entry seen combinationally so START is usable at once
    assign instr = instr_t'(prom_mem[rd_ptr]);

    always_ff @(posedge sys_clk_in or posedge sys_reset_in) begin
        if (sys_reset_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            run_q  <= 1'b0;
            irq_q  <= 1'b0;
        end else begin
            if (clear_wr) begin
                wr_ptr <= '0;
            end else if (push_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            // restart from entry 0 on every START
            if (start_wr) begin
                rd_ptr <= '0;
            end else if (instr_taken) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (start_wr) begin
                run_q <= 1'b1;
            end else if (run_done) begin
                run_q <= 1'b0;
            end

            // set wins over a clear in the same cycle
            if (run_done) begin
                irq_q <= 1'b1;
            end else if (irq_clear_wr) begin
                irq_q <= 1'b0;
            end
        end
    end

    // read mux, anything unmapped gets the marker word
    always_comb begin
        case (csr_req.address)
            CSR_STATUS: rd_value = {{(WORD_W-2){1'b0}}, irq_q, run_q};
            CSR_WRPTR:  rd_value = {{(WORD_W-PROM_ADDR_W){1'b0}}, wr_ptr};
            default:    rd_value = BAD_READ_VALUE;
        endcase
    end

    // every read answered one cycle later
    always_ff @(posedge sys_clk_in or posedge sys_reset_in) begin
        if (sys_reset_in) begin
            rsp_q <= '0;
        end else begin
            rsp_q.readdatavalid <= csr_req.read;
            if (csr_req.read) begin
                rsp_q.readdata <= rd_value;
            end
        end
    end

    assign csr_rsp  = rsp_q;
    assign run      = run_q;
    assign prom_irq = irq_q;

endmodule

`default_nettype wire

/* imc_pkg.sv */
//////////////////////////////////////////////////
// shared widths and constants for the compute core
// opcode, control address and sequencer state enums
// instruction, host, control and row command structs
//////////////////////////////////////////////////
`default_nettype none

package imc_pkg;

    // data and instruction word
    localparam int WORD_W      = 32;

    // row array geometry
    localparam int ROW_ADDR_W  = 8;
    localparam int ROW_COUNT   = 256;

    // program buffer geometry
    localparam int PROM_ADDR_W = 8;
    localparam int PROM_DEPTH  = 256;

    // bus address widths, host bit 8 selects row load
    localparam int CSR_ADDR_W  = 4;
    localparam int HOST_ADDR_W = 9;

    // returned for any unmapped control read
    localparam logic [WORD_W-1:0] BAD_READ_VALUE = 32'hDEAD_C0DE;

    // shift amount taken from low bits of dst
    localparam int SHIFT_W     = 5;

    // opcodes, LOAD only used internally for host writes
    typedef enum logic [7:0] {
        OP_LOAD  = 8'h00,
        OP_MOVE  = 8'h01,
        OP_ORC   = 8'h03,
        OP_ANDC  = 8'h04,
        OP_XORC  = 8'h05,
        OP_LSHFT = 8'h08,
        OP_RSHFT = 8'h09
    } imc_op_e;

    // control register map
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_PUSH      = 4'h0,
        CSR_START     = 4'h1,
        CSR_CLEAR     = 4'h2,
        CSR_STATUS    = 4'h3,
        CSR_WRPTR     = 4'h4,
        CSR_IRQ_CLEAR = 4'h5
    } csr_addr_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_HREAD1,
        ST_HREAD2,
        ST_FETCH,
        ST_ISSUE,
        ST_EXEC
    } seq_state_e;

    // opcode in the top byte, then three row fields
    typedef struct packed {
        imc_op_e               opcode;
        logic [ROW_ADDR_W-1:0] src_a;
        logic [ROW_ADDR_W-1:0] src_b;
        logic [ROW_ADDR_W-1:0] dst;
    } instr_t;

    typedef struct packed {
        logic                   write;
        logic                   read;
        logic [HOST_ADDR_W-1:0] address;
        logic [WORD_W-1:0]      writedata;
    } host_req_t;

    typedef struct packed {
        logic              waitrequest;
        logic [WORD_W-1:0] readdata;
        logic              readdatavalid;
    } host_rsp_t;

    typedef struct packed {
        logic                  write;
        logic                  read;
        logic [CSR_ADDR_W-1:0] address;
        logic [WORD_W-1:0]     writedata;
    } csr_req_t;

    typedef struct packed {
        logic [WORD_W-1:0] readdata;
        logic              readdatavalid;
    } csr_rsp_t;

    // one cycle of array control from the sequencer
    typedef struct packed {
        logic [ROW_ADDR_W-1:0] rd_addr_a;
        logic [ROW_ADDR_W-1:0] rd_addr_b;
        logic                  wr_en;
        logic [ROW_ADDR_W-1:0] wr_addr;
        imc_op_e               kind;
        logic [SHIFT_W-1:0]    shift;
        logic [WORD_W-1:0]     load_data;
    } row_cmd_t;

endpackage

`default_nettype wire
